// ==== source/Cpu6502Pkg.sv ====
/* Shared types and constants for the execute datapath. The 6502 widths are fixed, so nothing
   here is parameterized. */
package Cpu6502Pkg;

    // ALU operation codes, as carried in the micro-op
    typedef enum logic [3:0] {
        ALU_OP_AND    = 4'd0,
        ALU_OP_OR     = 4'd1,
        ALU_OP_EOR    = 4'd2,
        ALU_OP_ADC    = 4'd3,
        ALU_OP_SBC    = 4'd4,
        ALU_OP_ADD    = 4'd5,
        ALU_OP_SUB    = 4'd6,
        ALU_OP_BIT    = 4'd7,
        ALU_OP_CMP    = 4'd8,
        ALU_OP_SETBIT = 4'd9,
        ALU_OP_CLRBIT = 4'd10,
        ALU_OP_COPY   = 4'd11,
        ALU_OP_INC    = 4'd12,
        ALU_OP_DEC    = 4'd13,
        ALU_OP_FIXUP  = 4'd14,
        ALU_OP_SGL    = 4'd15
    } aluOp;

    // Single-operand codes, placed in the ext field when op is ALU_OP_SGL
    typedef enum logic [2:0] {
        ALU_SOP_ASL    = 3'd0,
        ALU_SOP_LSR    = 3'd1,
        ALU_SOP_ROL    = 3'd2,
        ALU_SOP_ROR    = 3'd3,
        ALU_SOP_TEST_N = 3'd4,
        ALU_SOP_TEST_C = 3'd5,
        ALU_SOP_TEST_V = 3'd6,
        ALU_SOP_TEST_Z = 3'd7
    } aluSop;

    // Operand source and write-back target.
    // As a destination, REG_DATA and REG_NONE both discard the result
    typedef enum logic [2:0] {
        REG_A    = 3'd0,
        REG_X    = 3'd1,
        REG_Y    = 3'd2,
        REG_S    = 3'd3,
        REG_P    = 3'd4,
        REG_DATA = 3'd5,
        REG_NONE = 3'd6
    } regSel;

    // One micro-operation; flagMask is ordered N, V, Z, C from the top bit down
    typedef struct packed {
        aluOp       op;
        logic [2:0] ext;
        regSel      srcA;
        regSel      srcB;
        regSel      dest;
        logic [3:0] flagMask;
    } microOp;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
        logic branch;
    } aluFlags;

    // Positions inside flagMask
    localparam int MASK_N = 3;
    localparam int MASK_V = 2;
    localparam int MASK_Z = 1;
    localparam int MASK_C = 0;

    // Positions inside the P register
    localparam int N_BIT_IN_P  = 7;
    localparam int V_BIT_IN_P  = 6;
    localparam int B5_BIT_IN_P = 5;
    localparam int D_BIT_IN_P  = 3;
    localparam int Z_BIT_IN_P  = 1;
    localparam int C_BIT_IN_P  = 0;

    // I flag and the unused bit 5 are set out of reset
    localparam logic [7:0] P_RESET = 8'h24;
    localparam logic [7:0] S_RESET = 8'hFF;

endpackage

// ==== source/Cpu6502Alu.sv ====
/* Purely combinational. Decimal correction is applied to ADC and SBC only and assumes valid BCD
   operands; undefined codes give a zero result with carry and overflow passed through. */
`timescale 1ns/100ps

module Cpu6502Alu
    import Cpu6502Pkg::*;
(
    input  logic [7:0] operandA,
    input  logic [7:0] operandB,
    input  logic       carryIn,
    input  logic       overflowIn,
    input  logic       decimalMode,
    input  aluOp       op,
    input  logic [2:0] ext,
    output logic [7:0] result,
    output aluFlags    flags
);

    aluSop      sop;
    logic       subtract;
    logic       withCarry;
    logic       incDec;
    logic       decAdd;
    logic       decSub;
    logic [7:0] adderOperandB;
    logic [7:0] addend2;
    logic       adderCarryIn;
    logic [4:0] rawSumL;
    logic [4:0] rawSumH;
    logic       halfCarry;
    logic       fullCarry;
    logic [3:0] finalSumL;
    logic [3:0] finalSumH;
    logic [7:0] finalSum;
    logic       adderOverflow;
    logic       carryOut;
    logic       overflowOut;
    logic       negFromB;
    logic       branch;

    assign sop = aluSop'(ext);

    // FIXUP steps by one in the direction given by the sign of operandB,
    // which is how a page-crossing carry or borrow gets applied to a high byte
    assign subtract = (op == ALU_OP_SBC) || (op == ALU_OP_SUB) || (op == ALU_OP_CMP) ||
                      (op == ALU_OP_DEC) || (op == ALU_OP_FIXUP && operandB[7]);
    assign withCarry = (op == ALU_OP_ADC) || (op == ALU_OP_SBC);
    assign incDec = (op == ALU_OP_INC) || (op == ALU_OP_DEC) || (op == ALU_OP_FIXUP);

    assign decAdd = decimalMode & withCarry & ~subtract;
    assign decSub = decimalMode & withCarry & subtract;

    assign adderOperandB = incDec ? 8'd1 : operandB;
    assign addend2 = subtract ? ~adderOperandB : adderOperandB;

    // Without an incoming carry a subtract needs the +1 of the two's complement
    assign adderCarryIn = withCarry ? carryIn : subtract;

    // Split-nibble adder so the decimal carry can be detected between the halves
    assign rawSumL = {1'b0, operandA[3:0]} + {1'b0, addend2[3:0]} + {4'd0, adderCarryIn};
    assign halfCarry = rawSumL[4] | (decAdd & (rawSumL[3:1] >= 3'd5));
    assign rawSumH = {1'b0, operandA[7:4]} + {1'b0, addend2[7:4]} + {4'd0, halfCarry};
    assign fullCarry = rawSumH[4] | (decAdd & (rawSumH[3:1] >= 3'd5));

    // A decimal add past 9 gets +6; a decimal borrow gets +10, which is -6 modulo 16
    always_comb begin
        if (decAdd && halfCarry) begin
            finalSumL = rawSumL[3:0] + 4'd6;
        end else if (decSub && !halfCarry) begin
            finalSumL = rawSumL[3:0] + 4'd10;
        end else begin
            finalSumL = rawSumL[3:0];
        end
    end

    always_comb begin
        if (decAdd && fullCarry) begin
            finalSumH = rawSumH[3:0] + 4'd6;
        end else if (decSub && !fullCarry) begin
            finalSumH = rawSumH[3:0] + 4'd10;
        end else begin
            finalSumH = rawSumH[3:0];
        end
    end

    assign finalSum = {finalSumH, finalSumL};
    assign adderOverflow = operandA[7] ^ addend2[7] ^ finalSum[7] ^ fullCarry;

    always_comb begin
        result      = 8'h00;
        carryOut    = carryIn;
        overflowOut = overflowIn;
        branch      = 1'b0;
        negFromB    = 1'b0;
        case (op)
            ALU_OP_AND:    result = operandA & operandB;
            ALU_OP_OR:     result = operandA | operandB;
            ALU_OP_EOR:    result = operandA ^ operandB;
            ALU_OP_ADC, ALU_OP_SBC: begin
                result      = finalSum;
                carryOut    = fullCarry;
                overflowOut = adderOverflow;
                branch      = fullCarry;
            end
            // Address arithmetic leaves C and V alone and reports the carry as a branch
            ALU_OP_ADD, ALU_OP_SUB: begin
                result = finalSum;
                branch = fullCarry;
            end
            ALU_OP_BIT: begin
                result      = operandA & operandB;
                overflowOut = operandB[6];
                negFromB    = 1'b1;
            end
            ALU_OP_CMP: begin
                result   = finalSum;
                carryOut = fullCarry;
                negFromB = 1'b1;
            end
            ALU_OP_SETBIT: result = operandA | (8'h01 << ext);
            ALU_OP_CLRBIT: result = operandA & ~(8'h01 << ext);
            ALU_OP_COPY:   result = operandA;
            ALU_OP_INC, ALU_OP_DEC, ALU_OP_FIXUP: result = finalSum;
            ALU_OP_SGL: begin
                case (sop)
                    ALU_SOP_ASL: begin
                        result   = {operandA[6:0], 1'b0};
                        carryOut = operandA[7];
                    end
                    ALU_SOP_LSR: begin
                        result   = {1'b0, operandA[7:1]};
                        carryOut = operandA[0];
                    end
                    ALU_SOP_ROL: begin
                        result   = {operandA[6:0], carryIn};
                        carryOut = operandA[7];
                    end
                    ALU_SOP_ROR: begin
                        result   = {carryIn, operandA[7:1]};
                        carryOut = operandA[0];
                    end
                    // Flag tests expect the status byte on operandA
                    ALU_SOP_TEST_N: begin
                        result = operandA;
                        branch = operandA[N_BIT_IN_P];
                    end
                    ALU_SOP_TEST_C: begin
                        result = operandA;
                        branch = operandA[C_BIT_IN_P];
                    end
                    ALU_SOP_TEST_V: begin
                        result = operandA;
                        branch = operandA[V_BIT_IN_P];
                    end
                    ALU_SOP_TEST_Z: begin
                        result = operandA;
                        branch = operandA[Z_BIT_IN_P];
                    end
                    default: result = 8'h00;
                endcase
            end
            default: result = 8'h00;
        endcase
    end

    assign flags = '{
        carry:    carryOut,
        zero:     ~|result,
        negative: negFromB ? operandB[7] : result[7],
        overflow: overflowOut,
        branch:   branch
    };

    // Known inputs must never leave X on the result or the flags
    always_comb begin
        if (!$isunknown({op, ext, operandA, operandB, carryIn, overflowIn, decimalMode})) begin
            assert (!$isunknown({result, flags}))
                else $error("ALU output has unknown bits for op %s", op.name());
        end
    end

endmodule

// ==== source/Cpu6502RegisterFile.sv ====
/* Holds A, X, Y and S only; P lives in the status register and arrives here as an input.
   A destination of P, DATA or NONE leaves these registers unchanged. */
`timescale 1ns/100ps

module Cpu6502RegisterFile
    import Cpu6502Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       execute,
    input  regSel      srcA,
    input  regSel      srcB,
    input  regSel      dest,
    input  logic [7:0] status,
    input  logic [7:0] dataIn,
    input  logic [7:0] result,
    output logic [7:0] operandA,
    output logic [7:0] operandB,
    output logic [7:0] regA,
    output logic [7:0] regX,
    output logic [7:0] regY,
    output logic [7:0] regS
);

    function automatic logic [7:0] selectOperand(input regSel sel);
        case (sel)
            REG_A:    return regA;
            REG_X:    return regX;
            REG_Y:    return regY;
            REG_S:    return regS;
            REG_P:    return status;
            REG_DATA: return dataIn;
            default:  return 8'h00;
        endcase
    endfunction

    always_comb begin
        operandA = selectOperand(srcA);
        operandB = selectOperand(srcB);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regA <= 8'h00;
            regX <= 8'h00;
            regY <= 8'h00;
            regS <= S_RESET;
        end else if (execute) begin
            case (dest)
                REG_A:   regA <= result;
                REG_X:   regX <= result;
                REG_Y:   regY <= result;
                REG_S:   regS <= result;
                default: ;
            endcase
        end
    end

    // A cycle without execute must leave every working register untouched
    assert property (@(posedge clk) disable iff (!rstN)
        !execute |=> $stable({regA, regX, regY, regS}))
        else $error("Working register changed without execute");

endmodule

// ==== source/Cpu6502StatusRegister.sv ====
/* D and I change only through a whole-byte load; bit 5 always reads as 1.
   branchFlag is updated only on execute and holds otherwise. */
`timescale 1ns/100ps

module Cpu6502StatusRegister
    import Cpu6502Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       execute,
    input  logic       loadAll,
    input  logic [3:0] flagMask,
    input  logic [7:0] result,
    input  aluFlags    flags,
    output logic [7:0] status,
    output logic       branchFlag
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status     <= P_RESET;
            branchFlag <= 1'b0;
        end else if (execute) begin
            branchFlag <= flags.branch;
            // A whole-byte load wins over the per-flag mask
            if (loadAll) begin
                status <= result | (8'h01 << B5_BIT_IN_P);
            end else begin
                if (flagMask[MASK_N]) begin
                    status[N_BIT_IN_P] <= flags.negative;
                end
                if (flagMask[MASK_V]) begin
                    status[V_BIT_IN_P] <= flags.overflow;
                end
                if (flagMask[MASK_Z]) begin
                    status[Z_BIT_IN_P] <= flags.zero;
                end
                if (flagMask[MASK_C]) begin
                    status[C_BIT_IN_P] <= flags.carry;
                end
            end
        end
    end

    // Holds across reset values, masked merges and full loads from any source
    assert property (@(posedge clk) disable iff (!rstN) status[B5_BIT_IN_P] == 1'b1)
        else $error("Status bit 5 read as 0");

endmodule

// ==== source/Cpu6502Datapath.sv ====
/* One micro-op per cycle with a one-cycle execute strobe and no back-pressure.
   Results and flags are visible on the outputs one edge after execute. */
`timescale 1ns/100ps

module Cpu6502Datapath
    import Cpu6502Pkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       execute,
    input  microOp     uop,
    input  logic [7:0] dataIn,
    output logic [7:0] regA,
    output logic [7:0] regX,
    output logic [7:0] regY,
    output logic [7:0] regS,
    output logic [7:0] status,
    output logic       branchFlag
);

    logic [7:0] operandA;
    logic [7:0] operandB;
    logic [7:0] aluResult;
    aluFlags    aluFlagsOut;
    logic       loadAll;

    assign loadAll = (uop.dest == REG_P);

    Cpu6502RegisterFile registerFile (
        .clk      (clk),
        .rstN     (rstN),
        .execute  (execute),
        .srcA     (uop.srcA),
        .srcB     (uop.srcB),
        .dest     (uop.dest),
        .status   (status),
        .dataIn   (dataIn),
        .result   (aluResult),
        .operandA (operandA),
        .operandB (operandB),
        .regA     (regA),
        .regX     (regX),
        .regY     (regY),
        .regS     (regS)
    );

    Cpu6502Alu alu (
        .operandA    (operandA),
        .operandB    (operandB),
        .carryIn     (status[C_BIT_IN_P]),
        .overflowIn  (status[V_BIT_IN_P]),
        .decimalMode (status[D_BIT_IN_P]),
        .op          (uop.op),
        .ext         (uop.ext),
        .result      (aluResult),
        .flags       (aluFlagsOut)
    );

    Cpu6502StatusRegister statusRegister (
        .clk        (clk),
        .rstN       (rstN),
        .execute    (execute),
        .loadAll    (loadAll),
        .flagMask   (uop.flagMask),
        .result     (aluResult),
        .flags      (aluFlagsOut),
        .status     (status),
        .branchFlag (branchFlag)
    );

endmodule

// ==== bench/Cpu6502DatapathTb.sv ====
/* Self-checking testbench for the execute datapath. Table rows carry hand-worked BCD and flag
   values; the random phase runs in binary mode only and is checked against a reference model. */
`timescale 1ns/100ps

module Cpu6502DatapathTb
    import Cpu6502Pkg::*;
;

    typedef struct packed {
        logic       exec;
        microOp     uop;
        logic [7:0] data;
        logic [7:0] expReg;
        logic [7:0] expP;
        logic       expBr;
    } tableRow;

    typedef struct packed {
        logic [7:0] res;
        logic       c;
        logic       z;
        logic       n;
        logic       v;
        logic       br;
    } refOut;

    logic       clk;
    logic       rstN;
    logic       execute;
    microOp     uop;
    logic [7:0] dataIn;
    logic [7:0] regA;
    logic [7:0] regX;
    logic [7:0] regY;
    logic [7:0] regS;
    logic [7:0] status;
    logic       branchFlag;

    tableRow    rows[$];
    logic [31:0] lcgState = 32'h36ba;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] mA, mX, mY, mS, mP;
    logic       mBr;

    Cpu6502Datapath DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic microOp uopOf(aluOp op, logic [2:0] ext, regSel a, regSel b, regSel d,
                                     logic [3:0] mask);
        microOp u;
        u.op = op;
        u.ext = ext;
        u.srcA = a;
        u.srcB = b;
        u.dest = d;
        u.flagMask = mask;
        return u;
    endfunction

    function automatic int bcdToInt(logic [7:0] b);
        return b[7:4] * 10 + b[3:0];
    endfunction

    function automatic logic [7:0] intToBcd(int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    // Result and flags worked out from the 6502 rules for each operation
    function automatic refOut refAlu(aluOp op, logic [2:0] ext, logic [7:0] a, logic [7:0] b,
                                     logic cIn, logic vIn, logic dIn);
        refOut o;
        logic [8:0] s;
        logic negB;
        int dv;
        o = '0;
        o.c = cIn;
        o.v = vIn;
        negB = 1'b0;
        case (op)
            ALU_OP_AND: o.res = a & b;
            ALU_OP_OR:  o.res = a | b;
            ALU_OP_EOR: o.res = a ^ b;
            ALU_OP_ADC, ALU_OP_SBC: begin
                if (dIn && op == ALU_OP_ADC) begin
                    dv = bcdToInt(a) + bcdToInt(b) + cIn;
                    o.c = dv > 99;
                    o.res = intToBcd(dv % 100);
                end else if (dIn) begin
                    dv = bcdToInt(a) - bcdToInt(b) - (1 - cIn);
                    o.c = dv >= 0;
                    o.res = intToBcd(dv < 0 ? dv + 100 : dv);
                end else begin
                    s = (op == ALU_OP_ADC) ? a + b + cIn : a + {1'b0, ~b} + cIn;
                    o.res = s[7:0];
                    o.c = s[8];
                    o.v = ((op == ALU_OP_ADC) ? (a[7] == b[7]) : (a[7] != b[7]))
                          && (o.res[7] != a[7]);
                end
                o.br = o.c;
            end
            ALU_OP_ADD: begin
                s = a + b;
                o.res = s[7:0];
                o.br = s[8];
            end
            ALU_OP_SUB: begin
                o.res = a - b;
                o.br = a >= b;
            end
            ALU_OP_CMP: begin
                o.res = a - b;
                o.c = a >= b;
                negB = 1'b1;
            end
            ALU_OP_BIT: begin
                o.res = a & b;
                o.v = b[6];
                negB = 1'b1;
            end
            ALU_OP_SETBIT: begin
                o.res = a;
                o.res[ext] = 1'b1;
            end
            ALU_OP_CLRBIT: begin
                o.res = a;
                o.res[ext] = 1'b0;
            end
            ALU_OP_COPY:   o.res = a;
            ALU_OP_INC:    o.res = a + 8'd1;
            ALU_OP_DEC:    o.res = a - 8'd1;
            ALU_OP_FIXUP:  o.res = b[7] ? a - 8'd1 : a + 8'd1;
            default: begin
                case (ext)
                    3'd0: {o.c, o.res} = {a, 1'b0};
                    3'd1: {o.res, o.c} = {1'b0, a};
                    3'd2: {o.c, o.res} = {a, cIn};
                    3'd3: {o.res, o.c} = {cIn, a};
                    3'd4: {o.res, o.br} = {a, a[7]};
                    3'd5: {o.res, o.br} = {a, a[0]};
                    3'd6: {o.res, o.br} = {a, a[6]};
                    default: {o.res, o.br} = {a, a[1]};
                endcase
            end
        endcase
        o.z = (o.res == 8'h00);
        o.n = negB ? b[7] : o.res[7];
        return o;
    endfunction

    function automatic logic [7:0] modelOperand(regSel sel, logic [7:0] data);
        case (sel)
            REG_A:    return mA;
            REG_X:    return mX;
            REG_Y:    return mY;
            REG_S:    return mS;
            REG_P:    return mP;
            REG_DATA: return data;
            default:  return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] dutReg(regSel sel);
        case (sel)
            REG_A:   return regA;
            REG_X:   return regX;
            REG_Y:   return regY;
            default: return regS;
        endcase
    endfunction

    task automatic checkValue(string name, logic [7:0] exp, logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Drives one micro-op on the falling edge and returns on the next falling edge
    task automatic runStep(logic exec, microOp u, logic [7:0] data);
        refOut o;
        execute = exec;
        uop = u;
        dataIn = data;
        o = refAlu(u.op, u.ext, modelOperand(u.srcA, data), modelOperand(u.srcB, data),
                   mP[C_BIT_IN_P], mP[V_BIT_IN_P], mP[D_BIT_IN_P]);
        @(negedge clk);
        if (exec) begin
            mBr = o.br;
            case (u.dest)
                REG_A: mA = o.res;
                REG_X: mX = o.res;
                REG_Y: mY = o.res;
                REG_S: mS = o.res;
                REG_P: mP = o.res | 8'h20;
                default: ;
            endcase
            if (u.dest != REG_P) begin
                if (u.flagMask[MASK_N]) mP[N_BIT_IN_P] = o.n;
                if (u.flagMask[MASK_V]) mP[V_BIT_IN_P] = o.v;
                if (u.flagMask[MASK_Z]) mP[Z_BIT_IN_P] = o.z;
                if (u.flagMask[MASK_C]) mP[C_BIT_IN_P] = o.c;
            end
        end
    endtask

    task automatic addRow(logic exec, microOp u, logic [7:0] data, logic [7:0] expReg,
                          logic [7:0] expP, logic expBr);
        tableRow row;
        row = '{exec, u, data, expReg, expP, expBr};
        rows.push_back(row);
    endtask

    initial begin
        // Each row holds exec, micro-op, data byte, expected dest register, expected P and branch
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_A, 4'b1010), 8'h7F, 8'h7F, 8'h24, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_X, 4'b1010), 8'h80, 8'h80, 8'hA4, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_Y, 4'b1010), 8'h00, 8'h00, 8'h26, 0);
        addRow(1, uopOf(ALU_OP_AND, 0, REG_A, REG_DATA, REG_A, 4'b1010), 8'h0F, 8'h0F, 8'h24, 0);
        addRow(1, uopOf(ALU_OP_OR, 0, REG_A, REG_X, REG_A, 4'b1010), 8'h00, 8'h8F, 8'hA4, 0);
        addRow(1, uopOf(ALU_OP_EOR, 0, REG_A, REG_DATA, REG_A, 4'b1010), 8'hFF, 8'h70, 8'h24, 0);
        addRow(1, uopOf(ALU_OP_BIT, 0, REG_A, REG_DATA, REG_NONE, 4'b1110), 8'hC0, 8'h00, 8'hE4, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'h00, 8'h00, 8'h20, 0);
        // Binary arithmetic with the signed overflow corners
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_A, 4'b0000), 8'h7F, 8'h7F, 8'h20, 0);
        addRow(1, uopOf(ALU_OP_ADC, 0, REG_A, REG_DATA, REG_A, 4'b1111), 8'h01, 8'h80, 8'hE0, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'h01, 8'h00, 8'h21, 0);
        addRow(1, uopOf(ALU_OP_SBC, 0, REG_A, REG_DATA, REG_A, 4'b1111), 8'h01, 8'h7F, 8'h61, 1);
        addRow(1, uopOf(ALU_OP_CMP, 0, REG_A, REG_DATA, REG_NONE, 4'b1011), 8'h7F, 8'h00, 8'h63, 0);
        addRow(1, uopOf(ALU_OP_CMP, 0, REG_A, REG_DATA, REG_NONE, 4'b1011), 8'h80, 8'h00, 8'hE0, 0);
        addRow(1, uopOf(ALU_OP_INC, 0, REG_X, REG_NONE, REG_X, 4'b1111), 8'h00, 8'h81, 8'hE0, 0);
        addRow(1, uopOf(ALU_OP_DEC, 0, REG_Y, REG_NONE, REG_Y, 4'b1111), 8'h00, 8'hFF, 8'hE0, 0);
        // Decimal mode
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'h08, 8'h00, 8'h28, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_A, 4'b0000), 8'h58, 8'h58, 8'h28, 0);
        addRow(1, uopOf(ALU_OP_ADC, 0, REG_A, REG_DATA, REG_A, 4'b0011), 8'h46, 8'h04, 8'h29, 1);
        addRow(1, uopOf(ALU_OP_SBC, 0, REG_A, REG_DATA, REG_A, 4'b0011), 8'h05, 8'h99, 8'h28, 0);
        addRow(1, uopOf(ALU_OP_SBC, 0, REG_A, REG_DATA, REG_A, 4'b0011), 8'h98, 8'h00, 8'h2B, 1);
        // Shifts, rotates and single bits
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'h00, 8'h00, 8'h20, 0);
        addRow(1, uopOf(ALU_OP_SGL, 0, REG_X, REG_NONE, REG_X, 4'b1011), 8'h00, 8'h02, 8'h21, 0);
        addRow(1, uopOf(ALU_OP_SGL, 2, REG_X, REG_NONE, REG_X, 4'b1011), 8'h00, 8'h05, 8'h20, 0);
        addRow(1, uopOf(ALU_OP_SGL, 3, REG_X, REG_NONE, REG_X, 4'b1011), 8'h00, 8'h02, 8'h21, 0);
        addRow(1, uopOf(ALU_OP_SGL, 1, REG_X, REG_NONE, REG_X, 4'b1011), 8'h00, 8'h01, 8'h20, 0);
        addRow(1, uopOf(ALU_OP_SGL, 1, REG_X, REG_NONE, REG_X, 4'b1011), 8'h00, 8'h00, 8'h23, 0);
        addRow(1, uopOf(ALU_OP_SETBIT, 6, REG_A, REG_NONE, REG_A, 4'b1010), 8'h00, 8'h40, 8'h21, 0);
        addRow(1, uopOf(ALU_OP_CLRBIT, 6, REG_A, REG_NONE, REG_A, 4'b0000), 8'h00, 8'h00, 8'h21, 0);
        // Flag tests on P and the ADD carry drive the branch output
        addRow(1, uopOf(ALU_OP_SGL, 5, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'h21, 1);
        addRow(1, uopOf(ALU_OP_SGL, 7, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'h21, 0);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'hC2, 8'h00, 8'hE2, 0);
        addRow(1, uopOf(ALU_OP_SGL, 4, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'hE2, 1);
        addRow(1, uopOf(ALU_OP_SGL, 6, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'hE2, 1);
        addRow(1, uopOf(ALU_OP_SGL, 7, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'hE2, 1);
        addRow(1, uopOf(ALU_OP_SGL, 5, REG_P, REG_NONE, REG_NONE, 4'b0000), 8'h00, 8'h00, 8'hE2, 0);
        addRow(1, uopOf(ALU_OP_ADD, 0, REG_DATA, REG_DATA, REG_NONE, 4'b1111), 8'h80, 8'h00, 8'h62, 1);
        addRow(0, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_A, 4'b1111), 8'h55, 8'h00, 8'h62, 1);
        addRow(1, uopOf(ALU_OP_COPY, 0, REG_DATA, REG_NONE, REG_P, 4'b0000), 8'h00, 8'h00, 8'h20, 0);
    end

    initial begin
        regSel srcList[6] = '{REG_A, REG_X, REG_Y, REG_S, REG_P, REG_DATA};
        regSel destList[5] = '{REG_A, REG_X, REG_Y, REG_S, REG_NONE};
        logic [31:0] r;
        microOp u;
        clk = 1'b0;
        rstN = 1'b0;
        execute = 1'b0;
        uop = '0;
        dataIn = 8'h00;
        {mA, mX, mY, mS, mP, mBr} = {24'h0, S_RESET, P_RESET, 1'b0};
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        checkValue("regA", 8'h00, regA);
        checkValue("regX", 8'h00, regX);
        checkValue("regY", 8'h00, regY);
        checkValue("regS", S_RESET, regS);
        checkValue("status", P_RESET, status);
        checkValue("branchFlag", 8'h00, {7'd0, branchFlag});
        foreach (rows[i]) begin
            runStep(rows[i].exec, rows[i].uop, rows[i].data);
            if (rows[i].uop.dest inside {REG_A, REG_X, REG_Y, REG_S}) begin
                checkValue(rows[i].uop.dest.name(), rows[i].expReg, dutReg(rows[i].uop.dest));
            end
            checkValue("status", rows[i].expP, status);
            checkValue("branchFlag", {7'd0, rows[i].expBr}, {7'd0, branchFlag});
        end
        // Random binary-mode operations; P is never a destination so D stays clear
        repeat (200) begin
            r = nextRand();
            u = uopOf(aluOp'(r[19:16]), r[22:20], srcList[r[25:23] % 6], srcList[r[28:26] % 6],
                      destList[r[31:29] % 5], r[15:12]);
            runStep(1'b1, u, nextRand() >> 20);
            checkValue("regA", mA, regA);
            checkValue("regX", mX, regX);
            checkValue("regY", mY, regY);
            checkValue("regS", mS, regS);
            checkValue("status", mP, status);
            checkValue("branchFlag", {7'd0, mBr}, {7'd0, branchFlag});
        end
        execute = 1'b0;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #1;
        #((16 + rows.size() + 200 + 20) * 8);
        $display("Simulation timed out before all tests completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/Cpu6502Pkg.sv
source/Cpu6502Alu.sv
source/Cpu6502RegisterFile.sv
source/Cpu6502StatusRegister.sv
source/Cpu6502Datapath.sv
bench/Cpu6502DatapathTb.sv

// ==== Makefile ====
# Verilator build and run for the execute datapath testbench

TOP = Cpu6502DatapathTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
